/* build.f */
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/regfile.sv
src/alu.sv
src/control.sv
src/datapath.sv
src/wb_master.sv
src/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

/* src/alu.sv */
`timescale 1ns/1ns

module alu import rv_isa_pkg::*, core_ctrl_pkg::*; (
	input alu_op_t alu_op_i,
	input word_t din1_i,
	input word_t din2_i,
	output word_t dout_o
);
	always_comb begin
		case (alu_op_i)
		ALU_ADD:
			dout_o = din1_i + din2_i;
		ALU_SUB:
			dout_o = din1_i - din2_i;
		ALU_AND:
			dout_o = din1_i & din2_i;
		ALU_OR:
			dout_o = din1_i | din2_i;
		ALU_XOR:
			dout_o = din1_i ^ din2_i;
		ALU_PASS_B:
			dout_o = din2_i;	// u-immediate straight through
		default:
			dout_o = '0;
		endcase
	end
endmodule

/* src/control.sv */
`timescale 1ns/1ns

module control import rv_isa_pkg::*, core_ctrl_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	input word_t ir_i,
	input logic taken_i,
	input logic done_i,
	output logic req_o,
	output logic bus_we_o,
	output logic pc_we_o,
	output logic ir_we_o,
	output logic rf_we_o,
	output alu_op_t alu_op_o,
	output alu_in1_sel_t alu_in1_sel_o,
	output alu_in2_sel_t alu_in2_sel_o,
	output next_pc_sel_t next_pc_sel_o,
	output wb_sel_t wb_sel_o,
	output addr_sel_t addr_sel_o
);
	ctrl_state_t state, next_state;
	logic issued;	// bus request already sent in this phase
	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	logic is_mem;
	logic writes_rd;

	function automatic alu_op_t funct_op(funct3_t f3, logic sub);
		case (f3)
		F3_ADD_SUB:
			return sub ? ALU_SUB : ALU_ADD;
		F3_XOR:
			return ALU_XOR;
		F3_OR:
			return ALU_OR;
		F3_AND:
			return ALU_AND;
		default:
			return ALU_ADD;
		endcase
	endfunction

	assign opcode = ir_i[6:0];
	assign funct3 = ir_i[14:12];
	assign funct7 = ir_i[31:25];

	// decode is held for the whole instruction, IR only changes at fetch
	always_comb begin
		alu_op_o = ALU_ADD;
		alu_in1_sel_o = ALU_IN1_RF;
		alu_in2_sel_o = ALU_IN2_RF;
		next_pc_sel_o = NEXT_PC_4;
		wb_sel_o = WB_ALU;
		is_mem = 1'b0;
		writes_rd = 1'b0;
		case (opcode)
		OP_LUI: begin
			alu_op_o = ALU_PASS_B;
			alu_in2_sel_o = ALU_IN2_IMM_U;
			writes_rd = 1'b1;
		end
		OP_OPIMM: begin
			alu_op_o = funct_op(funct3, 1'b0);
			alu_in2_sel_o = ALU_IN2_IMM_I;
			writes_rd = 1'b1;
		end
		OP_OP: begin
			alu_op_o = funct_op(funct3, funct7 == F7_SUB);
			writes_rd = 1'b1;
		end
		OP_LOAD: begin
			alu_in2_sel_o = ALU_IN2_IMM_I;
			wb_sel_o = WB_RDATA;
			is_mem = 1'b1;
			writes_rd = 1'b1;
		end
		OP_STORE: begin
			alu_in2_sel_o = ALU_IN2_IMM_S;
			is_mem = 1'b1;
		end
		OP_BRANCH: begin
			alu_in1_sel_o = ALU_IN1_PC;
			alu_in2_sel_o = ALU_IN2_IMM_B;
			next_pc_sel_o = taken_i ? NEXT_PC_BRANCH : NEXT_PC_4;	// not taken falls through
		end
		OP_JAL: begin
			alu_in1_sel_o = ALU_IN1_PC;
			alu_in2_sel_o = ALU_IN2_IMM_J;
			next_pc_sel_o = NEXT_PC_ALU;
			wb_sel_o = WB_PC_4;
			writes_rd = 1'b1;
		end
		default: ;	// unknown opcode, just pc+4
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
		FETCH:
			if (done_i)
				next_state = DECODE;
		DECODE:
			next_state = EXECUTE;
		EXECUTE:
			if (is_mem)
				next_state = MEMORY;
			else if (writes_rd)
				next_state = WRITEBACK;
			else
				next_state = FETCH;
		MEMORY:
			if (done_i)
				next_state = writes_rd ? WRITEBACK : FETCH;
		default:
			next_state = FETCH;
		endcase
	end

	assign req_o = (state == FETCH || state == MEMORY) && !issued;
	assign bus_we_o = (state == MEMORY) && (opcode == OP_STORE);
	assign ir_we_o = (state == FETCH) && done_i;
	assign pc_we_o = (state == EXECUTE);
	assign rf_we_o = (state == WRITEBACK);
	assign addr_sel_o = (state == MEMORY) ? ADDR_ALU : ADDR_PC;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= FETCH;
			issued <= 1'b0;
		end else begin
			state <= next_state;
			if (done_i)
				issued <= 1'b0;
			else if (req_o)
				issued <= 1'b1;
		end
	end
endmodule

/* src/core_ctrl_pkg.sv */
package core_ctrl_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B	// lui
	} alu_op_t;

	typedef enum logic {ALU_IN1_RF, ALU_IN1_PC} alu_in1_sel_t;

	typedef enum logic [2:0] {
		ALU_IN2_RF,
		ALU_IN2_IMM_I,
		ALU_IN2_IMM_S,
		ALU_IN2_IMM_B,
		ALU_IN2_IMM_U,
		ALU_IN2_IMM_J
	} alu_in2_sel_t;

	// branch takes the alu result only when the condition holds
	typedef enum logic [1:0] {NEXT_PC_4, NEXT_PC_ALU, NEXT_PC_BRANCH} next_pc_sel_t;

	typedef enum logic [1:0] {WB_ALU, WB_PC_4, WB_RDATA} wb_sel_t;

	typedef enum logic {ADDR_PC, ADDR_ALU} addr_sel_t;

	typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK} ctrl_state_t;

endpackage

/* src/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top import rv_isa_pkg::*, core_ctrl_pkg::*; #(
	parameter word_t RESET_PC = 32'h0001_0000
) (
	input logic clk_i,
	input logic reset_i,
	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output word_t adr_o,
	output word_t dat_o,
	input word_t dat_i,
	input logic ack_i
);
	logic req, bus_we, done, taken;
	logic pc_we, ir_we, rf_we;
	word_t ir, addr, wdata, rdata;
	alu_op_t alu_op;
	alu_in1_sel_t alu_in1_sel;
	alu_in2_sel_t alu_in2_sel;
	next_pc_sel_t next_pc_sel;
	wb_sel_t wb_sel;
	addr_sel_t addr_sel;

	control control (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ir_i(ir),
		.taken_i(taken),
		.done_i(done),
		.req_o(req),
		.bus_we_o(bus_we),
		.pc_we_o(pc_we),
		.ir_we_o(ir_we),
		.rf_we_o(rf_we),
		.alu_op_o(alu_op),
		.alu_in1_sel_o(alu_in1_sel),
		.alu_in2_sel_o(alu_in2_sel),
		.next_pc_sel_o(next_pc_sel),
		.wb_sel_o(wb_sel),
		.addr_sel_o(addr_sel)
	);

	datapath #(
		.RESET_PC(RESET_PC)
	) datapath (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.pc_we_i(pc_we),
		.ir_we_i(ir_we),
		.rf_we_i(rf_we),
		.alu_op_i(alu_op),
		.alu_in1_sel_i(alu_in1_sel),
		.alu_in2_sel_i(alu_in2_sel),
		.next_pc_sel_i(next_pc_sel),
		.wb_sel_i(wb_sel),
		.addr_sel_i(addr_sel),
		.rdata_i(rdata),
		.ir_o(ir),
		.taken_o(taken),
		.addr_o(addr),
		.wdata_o(wdata)
	);

	wb_master wb_master (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.req_i(req),
		.we_i(bus_we),
		.adr_i(addr),
		.dat_i(wdata),
		.done_o(done),
		.rdata_o(rdata),
		.cyc_o(cyc_o),
		.stb_o(stb_o),
		.we_o(we_o),
		.adr_o(adr_o),
		.dat_o(dat_o),
		.ack_i(ack_i),
		.wb_dat_i(dat_i)
	);
endmodule

/* src/datapath.sv */
`timescale 1ns/1ns

module datapath import rv_isa_pkg::*, core_ctrl_pkg::*; #(
	parameter word_t RESET_PC = 32'h0001_0000
) (
	input logic clk_i,
	input logic reset_i,
	input logic pc_we_i,
	input logic ir_we_i,
	input logic rf_we_i,
	input alu_op_t alu_op_i,
	input alu_in1_sel_t alu_in1_sel_i,
	input alu_in2_sel_t alu_in2_sel_i,
	input next_pc_sel_t next_pc_sel_i,
	input wb_sel_t wb_sel_i,
	input addr_sel_t addr_sel_i,
	input word_t rdata_i,
	output word_t ir_o,
	output logic taken_o,
	output word_t addr_o,
	output word_t wdata_o
);
	word_t pc;
	word_t ir;
	word_t ret_addr;	// pc+4 of the executing instruction, for the jal link

	word_t pc_4;
	word_t next_pc;
	word_t alu_din1;
	word_t alu_din2;
	word_t alu_dout;
	word_t rf_rin;
	word_t rf_rout1;
	word_t rf_rout2;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	reg_addr_t rs1, rs2, rd;
	funct3_t funct3;

	assign rs1 = ir[19:15];
	assign rs2 = ir[24:20];
	assign rd = ir[11:7];
	assign funct3 = ir[14:12];
	assign pc_4 = pc + 32'd4;

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	regfile regfile (
		.clk_i(clk_i),
		.rs1_i(rs1),
		.rs2_i(rs2),
		.rd_i(rd),
		.rin_i(rf_rin),
		.we_i(rf_we_i),
		.rout1_o(rf_rout1),
		.rout2_o(rf_rout2)
	);

	alu alu (
		.alu_op_i(alu_op_i),
		.din1_i(alu_din1),
		.din2_i(alu_din2),
		.dout_o(alu_dout)
	);

	always_comb begin
		case (funct3)
		F3_BEQ:
			taken_o = (rf_rout1 == rf_rout2);
		F3_BNE:
			taken_o = (rf_rout1 != rf_rout2);
		default:
			taken_o = 1'b0;
		endcase

		alu_din1 = (alu_in1_sel_i == ALU_IN1_PC) ? pc : rf_rout1;

		case (alu_in2_sel_i)
		ALU_IN2_IMM_I: alu_din2 = imm_i;
		ALU_IN2_IMM_S: alu_din2 = imm_s;
		ALU_IN2_IMM_B: alu_din2 = imm_b;
		ALU_IN2_IMM_U: alu_din2 = imm_u;
		ALU_IN2_IMM_J: alu_din2 = imm_j;
		default: alu_din2 = rf_rout2;
		endcase

		case (next_pc_sel_i)
		NEXT_PC_ALU:
			next_pc = alu_dout;
		NEXT_PC_BRANCH:
			next_pc = taken_o ? alu_dout : pc_4;
		default:
			next_pc = pc_4;
		endcase

		case (wb_sel_i)
		WB_PC_4: rf_rin = ret_addr;
		WB_RDATA: rf_rin = rdata_i;
		default: rf_rin = alu_dout;
		endcase

		addr_o = (addr_sel_i == ADDR_ALU) ? alu_dout : pc;
	end

	assign wdata_o = rf_rout2;
	assign ir_o = ir;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc <= RESET_PC;
			ir <= '0;
		end else begin
			if (pc_we_i)
				pc <= next_pc;
			if (ir_we_i)
				ir <= rdata_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (pc_we_i)
			ret_addr <= pc_4;
	end
endmodule

/* src/regfile.sv */
`timescale 1ns/1ns

module regfile import rv_isa_pkg::*; (
	input logic clk_i,
	input reg_addr_t rs1_i,
	input reg_addr_t rs2_i,
	input reg_addr_t rd_i,
	input word_t rin_i,
	input logic we_i,
	output word_t rout1_o,
	output word_t rout2_o
);
	word_t regs [32];

	// x0 is never written and reads as zero
	always_ff @(posedge clk_i) begin
		if (we_i && rd_i != 5'd0) begin
			regs[rd_i] <= rin_i;
		end
	end

	always_comb begin
		rout1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
		rout2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];
	end
endmodule

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

	typedef logic [31:0] word_t;	// data, address and instruction
	typedef logic [4:0] reg_addr_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// major opcodes of the supported subset
	localparam opcode_t OP_LUI = 7'b0110111;
	localparam opcode_t OP_OPIMM = 7'b0010011;
	localparam opcode_t OP_OP = 7'b0110011;
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL = 7'b1101111;

	// arithmetic funct3
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_OR = 3'b110;
	localparam funct3_t F3_AND = 3'b111;

	// branch funct3
	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;

	localparam funct7_t F7_SUB = 7'b0100000;

endpackage

/* src/wb_master.sv */
`timescale 1ns/1ns

module wb_master import rv_isa_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	input logic req_i,
	input logic we_i,
	input word_t adr_i,
	input word_t dat_i,
	output logic done_o,
	output word_t rdata_o,
	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output word_t adr_o,
	output word_t dat_o,
	input logic ack_i,
	input word_t wb_dat_i
);
	logic cyc;
	logic start;

	assign start = req_i && !cyc;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cyc <= 1'b0;
			we_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (cyc && ack_i) begin
				cyc <= 1'b0;	// drop one cycle after ack
				we_o <= 1'b0;
				done_o <= 1'b1;
			end else if (start) begin
				cyc <= 1'b1;
				we_o <= we_i;
			end
		end
	end

	// address and data held for the whole cycle, read data until next request
	always_ff @(posedge clk_i) begin
		if (start) begin
			adr_o <= adr_i;
			dat_o <= dat_i;
		end
		if (cyc && ack_i)
			rdata_o <= wb_dat_i;
	end

	assign cyc_o = cyc;
	assign stb_o = cyc;
endmodule

/* tests/cpu_checker.sv */
`timescale 1ns/1ns

module cpu_checker import rv_isa_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	input logic cyc_o,
	input logic stb_o,
	input logic we_o,
	input word_t adr_o,
	input word_t dat_o,
	input logic ack_i
);
	int errors = 0;	// read by the testbench at the end of the run

	stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i) stb_o |-> cyc_o)
	else begin
		$error("stb_o high outside a bus cycle");
		errors++;
	end

	// request held until the slave answers
	held_until_ack: assert property (@(posedge clk_i) disable iff (reset_i)
		stb_o && !ack_i |=> $stable(adr_o) && $stable(we_o) && $stable(dat_o))
	else begin
		$error("bus request changed before ack");
		errors++;
	end

	cyc_drops: assert property (@(posedge clk_i) disable iff (reset_i)
		cyc_o && ack_i |=> !cyc_o)
	else begin
		$error("cyc_o still high after an acknowledged access");
		errors++;
	end
endmodule

bind cpu_top cpu_checker bus_checks (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.cyc_o(cyc_o),
	.stb_o(stb_o),
	.we_o(we_o),
	.adr_o(adr_o),
	.dat_o(dat_o),
	.ack_i(ack_i)
);

/* tests/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb import rv_isa_pkg::*; ();
	localparam int CLK_PERIOD = 4;
	localparam word_t RESET_PC = 32'h0001_0000;
	localparam word_t MEM_BASE = 32'h0001_0000;
	localparam int MEM_WORDS = 1024;
	localparam word_t DATA_BASE = 32'h0001_0800;
	localparam word_t SEED = 32'd59674;
	localparam int NUM_TESTS = 9;
	localparam int INSTR_PER_TEST = 40;
	localparam int A_ADD = 0;
	localparam int A_SUB = 1;
	localparam int A_AND = 2;
	localparam int A_OR = 3;
	localparam int A_XOR = 4;

	logic clk_i;
	logic reset_i;
	logic cyc_o, stb_o, we_o, ack_i;
	word_t adr_o, dat_o, dat_i;

	word_t mem [MEM_WORDS];
	word_t prog [$];
	word_t exp_adr [$];
	word_t exp_dat [$];
	word_t rng_data, rng_wait;
	word_t wr_adr, wr_dat, last_rd;
	logic in_access, rd_valid, loop_hit, first_pending;
	int wait_left;
	int test_errs, total_errs, tests_run, tests_failed;
	string cur_name;
	event wr_ev;

	cpu_top #(
		.RESET_PC(RESET_PC)
	) DUT (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.cyc_o(cyc_o),
		.stb_o(stb_o),
		.we_o(we_o),
		.adr_o(adr_o),
		.dat_o(dat_o),
		.dat_i(dat_i),
		.ack_i(ack_i)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	function automatic word_t xorshift(word_t x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t ref_alu(int op, word_t a, word_t b);
		case (op)
		A_ADD: return a + b;
		A_SUB: return a - b;
		A_AND: return a & b;
		A_OR: return a | b;
		default: return a ^ b;
		endcase
	endfunction

	// instruction encoders, rv32i formats
	function automatic word_t enc_r(int op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
		logic [2:0] f3;
		logic [6:0] f7;
		f7 = (op == A_SUB) ? 7'b0100000 : 7'b0000000;
		case (op)
		A_AND: f3 = 3'b111;
		A_OR: f3 = 3'b110;
		A_XOR: f3 = 3'b100;
		default: f3 = 3'b000;
		endcase
		return {f7, rs2, rs1, f3, rd, OP_OP};
	endfunction

	function automatic word_t enc_i(opcode_t opc, logic [2:0] f3, reg_addr_t rd,
			reg_addr_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t enc_b(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
			logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic word_t enc_j(reg_addr_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	task automatic li(reg_addr_t rd, word_t v);
		word_t hi;
		hi = v + 32'h800;	// addi sign-extends the low part
		prog.push_back({hi[31:12], rd, OP_LUI});
		prog.push_back(enc_i(OP_OPIMM, 3'b000, rd, rd, v[11:0]));
	endtask

	task automatic rand_word(output word_t w);
		rng_data = xorshift(rng_data);
		w = rng_data;
	endtask

	task automatic expect_store(word_t a, word_t d);
		exp_adr.push_back(a);
		exp_dat.push_back(d);
	endtask

	task note_error();
		test_errs++;
		total_errs++;
	endtask

	// memory with random wait states
	always @(negedge clk_i) begin
		int idx;
		ack_i = 1'b0;
		if (cyc_o && stb_o) begin
			if (!in_access) begin
				in_access = 1'b1;
				rng_wait = xorshift(rng_wait);
				wait_left = rng_wait % 4;
			end
			if (wait_left != 0) begin
				wait_left--;
			end else begin
				in_access = 1'b0;
				idx = (adr_o - MEM_BASE) >> 2;
				if (first_pending) begin
					first_pending = 1'b0;
					if (adr_o !== RESET_PC) begin
						$display("CHECK FAILED %s: first fetch expected %h, actual %h",
							cur_name, RESET_PC, adr_o);
						note_error();
					end
				end
				if (adr_o < MEM_BASE || idx >= MEM_WORDS) begin
					$display("%s: bus access outside memory at %h", cur_name, adr_o);
					note_error();
					dat_i = '0;
				end else if (we_o) begin
					mem[idx] = dat_o;
					wr_adr = adr_o;
					wr_dat = dat_o;
					-> wr_ev;
				end else begin
					dat_i = mem[idx];
					if (rd_valid && adr_o == last_rd)
						loop_hit = 1'b1;	// jal to itself
					last_rd = adr_o;
					rd_valid = 1'b1;
				end
				ack_i = 1'b1;
			end
		end
	end

	always @(wr_ev) begin
		word_t ea, ed;
		if (exp_adr.size() == 0) begin
			$display("%s: unexpected store of %h to %h", cur_name, wr_dat, wr_adr);
			note_error();
		end else begin
			ea = exp_adr.pop_front();
			ed = exp_dat.pop_front();
			if (wr_adr !== ea) begin
				$display("CHECK FAILED %s: store address expected %h, actual %h",
					cur_name, ea, wr_adr);
				note_error();
			end
			if (wr_dat !== ed) begin
				$display("CHECK FAILED %s: store data expected %h, actual %h",
					cur_name, ed, wr_dat);
				note_error();
			end
		end
	end

	task automatic run_program(string name);
		int i;
		@(negedge clk_i);
		while (cyc_o === 1'b1)
			@(negedge clk_i);
		reset_i = 1'b1;
		cur_name = name;
		test_errs = 0;
		rd_valid = 1'b0;
		loop_hit = 1'b0;
		first_pending = 1'b1;
		for (i = 0; i < MEM_WORDS; i++)
			mem[i] = (MEM_BASE + 4 * i) ^ 32'h5a5a_c3c3;
		for (i = 0; i < prog.size(); i++)
			mem[i] = prog[i];
		for (i = 0; i < 16; i++) begin
			@(negedge clk_i);
			if (cyc_o !== 1'b0) begin
				$display("%s: bus cycle active during reset", name);
				note_error();
			end
		end
		reset_i = 1'b0;
		wait (loop_hit);
		@(negedge clk_i);
		if (exp_adr.size() != 0) begin
			$display("%s: %0d expected stores never happened", name, exp_adr.size());
			note_error();
		end
		if (test_errs == 0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, test_errs);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
	endtask

	task automatic test_arith(int round);
		word_t a, b;
		int k;
		rand_word(a);
		rand_word(b);
		prog.delete();
		li(1, DATA_BASE);
		li(2, a);
		li(3, b);
		for (k = 0; k < 5; k++) begin
			prog.push_back(enc_r(k, 4, 2, 3));
			prog.push_back(enc_s(4, 1, 12'(4 * k)));
			expect_store(DATA_BASE + 4 * k, ref_alu(k, a, b));
		end
		prog.push_back(enc_j(0, 21'd0));
		run_program($sformatf("arith_%0d", round));
	endtask

	task automatic test_load_store();
		word_t v;
		int k;
		prog.delete();
		li(1, DATA_BASE);
		for (k = 0; k < 4; k++) begin
			rand_word(v);
			li(2, v);
			prog.push_back(enc_s(2, 1, 12'(16 * k)));
			prog.push_back(enc_i(OP_LOAD, 3'b010, 5, 1, 12'(16 * k)));
			prog.push_back(enc_s(5, 1, 12'(16 * k + 8)));	// copy to second slot
			expect_store(DATA_BASE + 16 * k, v);
			expect_store(DATA_BASE + 16 * k + 8, v);
		end
		prog.push_back(enc_j(0, 21'd0));
		run_program("load_store");
	endtask

	task automatic test_branch(logic is_bne, logic equal);
		word_t a, b, r;
		logic taken;
		rand_word(a);
		rand_word(r);
		b = equal ? a : a ^ (r | 32'd1);
		taken = is_bne ? (a != b) : (a == b);
		prog.delete();
		li(1, DATA_BASE);
		li(2, a);
		li(3, b);
		prog.push_back(enc_b(is_bne ? F3_BNE : F3_BEQ, 2, 3, 13'd16));
		prog.push_back(enc_i(OP_OPIMM, 3'b000, 6, 0, 12'h111));	// fall-through marker
		prog.push_back(enc_s(6, 1, 12'd0));
		prog.push_back(enc_j(0, 21'd12));
		prog.push_back(enc_i(OP_OPIMM, 3'b000, 6, 0, 12'h222));
		prog.push_back(enc_s(6, 1, 12'd0));
		prog.push_back(enc_j(0, 21'd0));
		expect_store(DATA_BASE, taken ? 32'h222 : 32'h111);
		run_program($sformatf("%s_%s", is_bne ? "bne" : "beq", equal ? "equal" : "unequal"));
	endtask

	task automatic test_jal_link();
		int jal_idx;
		prog.delete();
		li(1, DATA_BASE);
		prog.push_back(enc_i(OP_OPIMM, 3'b000, 8, 0, 12'd0));
		jal_idx = prog.size();
		prog.push_back(enc_j(7, 21'd12));
		prog.push_back(enc_i(OP_OPIMM, 3'b000, 8, 0, 12'h05a));	// skipped
		prog.push_back(enc_s(8, 1, 12'd4));
		prog.push_back(enc_s(7, 1, 12'd0));
		prog.push_back(enc_j(0, 21'd0));
		expect_store(DATA_BASE, RESET_PC + 4 * jal_idx + 4);
		run_program("jal_link");
	endtask

	initial begin
		#(NUM_TESTS * INSTR_PER_TEST * 12 * CLK_PERIOD);
		$display("watchdog: the run did not finish in time");
		$display("test failed");
		$finish;
	end

	initial begin
		clk_i = 1'b0;
		reset_i = 1'b1;
		ack_i = 1'b0;
		dat_i = '0;
		rng_data = SEED;
		rng_wait = xorshift(SEED);
		in_access = 1'b0;
		wait_left = 0;
		rd_valid = 1'b0;
		loop_hit = 1'b0;
		first_pending = 1'b0;
		test_errs = 0;
		total_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_name = "init";

		test_arith(0);
		test_arith(1);
		test_arith(2);
		test_load_store();
		test_branch(1'b0, 1'b1);
		test_branch(1'b0, 1'b0);
		test_branch(1'b1, 1'b1);
		test_branch(1'b1, 1'b0);
		test_jal_link();

		$display("%0d tests run, %0d failing, %0d errors, %0d bus assertion errors",
			tests_run, tests_failed, total_errs, DUT.bus_checks.errors);
		if (tests_failed == 0 && total_errs == 0 && DUT.bus_checks.errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end
endmodule
